//--- filelist.f
+incdir+hw
hw/pbus_pkg.sv
hw/pbus_xbar.sv
hw/pbus_gpio.sv
hw/pbus_timer.sv
hw/peripheral_bus.sv
testbench/tb_peripheral_bus.sv

//--- run_sim.sh
#!/bin/sh
# build the peripheral bus testbench with Verilator and run it
# the exit status is the simulation result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module tb_peripheral_bus \
    --Mdir obj_dir -o tb_peripheral_bus \
    && ./obj_dir/tb_peripheral_bus \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- testbench/tb_peripheral_bus.sv
////////////////////////////////////////
// peripheral bus testbench
// drives the request port, models the
// registers and checks each response
////////////////////////////////////////

`include "pbus_config.svh"

`default_nettype none

module tb_peripheral_bus;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned CLK_PERIOD = 20;
    localparam int unsigned WAIT_LIMIT = 64;        // cycles per handshake or irq wait
    localparam int SLV_CODES [3] = '{`PBUS_SLV_GPIO, `PBUS_SLV_TIM0, `PBUS_SLV_TIM1};

    logic                 clock;
    logic                 arst_n;
    logic                 req_valid;
    logic                 req_we;
    pbus_pkg::pbus_addr_t req_addr;
    pbus_pkg::pbus_data_t req_wdata;
    pbus_pkg::pbus_strb_t req_strb;
    logic                 req_ready;
    logic                 rsp_valid;
    pbus_pkg::pbus_data_t rsp_rdata;
    logic                 rsp_err;
    logic                 rsp_ready;
    pbus_pkg::gpio_in_t   gpio_in;
    pbus_pkg::gpio_out_t  gpio_out;
    pbus_pkg::irq_vec_t   int_vec;

    integer               seed;                     // $random state
    pbus_pkg::gpio_out_t  out_model;                // expected OUT
    pbus_pkg::gpio_in_t   en_model;                 // expected IRQ_EN
    pbus_pkg::pbus_data_t tim_load_model [2];
    pbus_pkg::pbus_data_t tim_ctrl_model [2];

    peripheral_bus u_peripheral_bus (
        .clock_i     ( clock     ),
        .arst_n_i    ( arst_n    ),
        .req_valid_i ( req_valid ),
        .req_we_i    ( req_we    ),
        .req_addr_i  ( req_addr  ),
        .req_wdata_i ( req_wdata ),
        .req_strb_i  ( req_strb  ),
        .req_ready_o ( req_ready ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_rdata_o ( rsp_rdata ),
        .rsp_err_o   ( rsp_err   ),
        .rsp_ready_i ( rsp_ready ),
        .gpio_in_i   ( gpio_in   ),
        .gpio_out_o  ( gpio_out  ),
        .int_o       ( int_vec   )
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input pbus_pkg::pbus_data_t exp,
                               input pbus_pkg::pbus_data_t act);
        assert (act === exp) else begin
            stop_with_error($sformatf("[ERROR] t=%0t %s expected 0x%08h actual 0x%08h",
                                      $time, name, exp, act));
        end
    endtask

    function automatic pbus_pkg::pbus_addr_t reg_addr(input int code, input int idx);
        return (pbus_pkg::pbus_addr_t'(code) << `PBUS_SEL_LSB)
             | (pbus_pkg::pbus_addr_t'(idx) << `PBUS_IDX_LSB);
    endfunction

    // byte lane merge of a write into a register
    function automatic pbus_pkg::pbus_data_t merge_bytes(input pbus_pkg::pbus_data_t old_word,
                                                         input pbus_pkg::pbus_data_t new_word,
                                                         input pbus_pkg::pbus_strb_t strb);
        pbus_pkg::pbus_data_t merged;
        merged = old_word;
        for (int b = 0; b < `PBUS_STRB_W; b++) begin
            if (strb[b]) merged[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return merged;
    endfunction

    task automatic idle_cycles(input int unsigned n);
        repeat (n) @(negedge clock);
    endtask

    // one full request/response, hold = cycles of back-pressure
    task automatic run_access(input logic we, input pbus_pkg::pbus_addr_t addr,
                              input pbus_pkg::pbus_data_t wdata,
                              input pbus_pkg::pbus_strb_t strb, input int unsigned hold,
                              output pbus_pkg::pbus_data_t rdata, output logic err);
        int unsigned waited;
        waited = 0;
        @(negedge clock);
        req_valid = 1'b1;
        req_we    = we;
        req_addr  = addr;
        req_wdata = wdata;
        req_strb  = strb;
        while (!req_ready) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) stop_with_error("request was never accepted");
        end
        @(negedge clock);                           // accepted on the edge just passed
        req_valid = 1'b0;
        waited    = 0;
        while (!rsp_valid) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) stop_with_error("no response to an accepted request");
        end
        idle_cycles(hold);                          // response must hold meanwhile
        rsp_ready = 1'b1;
        rdata     = rsp_rdata;
        err       = rsp_err;
        @(negedge clock);
        rsp_ready = 1'b0;
    endtask

    task automatic bus_write(input pbus_pkg::pbus_addr_t addr, input pbus_pkg::pbus_data_t wdata,
                             input pbus_pkg::pbus_strb_t strb, input logic exp_err,
                             input string what);
        pbus_pkg::pbus_data_t rdata;
        logic                 err;
        run_access(1'b1, addr, wdata, strb, 0, rdata, err);
        check_value({"rsp_err_o writing ", what}, 32'(exp_err), 32'(err));
        check_value({"rsp_rdata_o writing ", what}, '0, rdata);     // writes carry no data
    endtask

    task automatic bus_read(input pbus_pkg::pbus_addr_t addr, input pbus_pkg::pbus_data_t exp,
                            input logic exp_err, input string what);
        pbus_pkg::pbus_data_t rdata;
        logic                 err;
        int unsigned          hold;
        hold = $unsigned($random(seed)) % 6;
        run_access(1'b0, addr, '0, '0, hold, rdata, err);
        check_value({"rsp_err_o reading ", what}, 32'(exp_err), 32'(err));
        check_value({"rsp_rdata_o reading ", what}, exp, rdata);
    endtask

    // wait for one int_o line, other lines in quiet must stay low
    task automatic await_irq(input int bit_idx, input logic level,
                             input pbus_pkg::irq_vec_t quiet);
        int unsigned waited;
        waited = 0;
        while (int_vec[bit_idx] !== level) begin
            @(negedge clock);
            check_value("int_o quiet lines", '0, 32'(int_vec & quiet));
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_error($sformatf("int_o[%0d] did not go to %0b in time", bit_idx, level));
            end
        end
    endtask

    ////////////////////////////////////////
    // handshake assertions
    ////////////////////////////////////////

    resp_latency: assert property (@(posedge clock) disable iff (!arst_n)
        (req_valid && req_ready) |=> rsp_valid)
        else stop_with_error("rsp_valid_o not high one cycle after acceptance");

    resp_cause: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(rsp_valid) |-> $past(req_valid && req_ready))
        else stop_with_error("rsp_valid_o rose without an accepted request");

    ready_low: assert property (@(posedge clock) disable iff (!arst_n)
        rsp_valid |-> !req_ready)
        else stop_with_error("req_ready_o high while a response is pending");

    resp_hold: assert property (@(posedge clock) disable iff (!arst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata) && $stable(rsp_err)))
        else stop_with_error("response changed under back-pressure");

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        pbus_pkg::gpio_in_t   pins;
        pbus_pkg::gpio_in_t   chg;
        pbus_pkg::pbus_data_t wdata;
        pbus_pkg::pbus_strb_t strb;
        pbus_pkg::pbus_data_t ctrl;
        pbus_pkg::irq_vec_t   quiet;
        int                   code;

        seed      = 32'h57fb_4f27;
        clock     = 1'b0;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_strb  = '0;
        rsp_ready = 1'b0;
        gpio_in   = '0;
        out_model = '0;
        en_model  = '0;
        tim_load_model = '{default: '0};
        tim_ctrl_model = '{default: '0};
        repeat (5) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // reset values
        check_value("rsp_valid_o", '0, 32'(rsp_valid));
        check_value("req_ready_o", 32'd1, 32'(req_ready));
        check_value("gpio_out_o", '0, 32'(gpio_out));
        check_value("int_o", '0, 32'(int_vec));

        // gpio output with random byte lanes
        repeat (12) begin
            wdata = $random(seed);
            strb  = pbus_pkg::pbus_strb_t'($random(seed));
            bus_write(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_OUT), wdata, strb, 1'b0, "GPIO OUT");
            out_model = pbus_pkg::gpio_out_t'(merge_bytes(32'(out_model), wdata, strb));
            check_value("gpio_out_o", 32'(out_model), 32'(gpio_out));
            bus_read(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_OUT), 32'(out_model), 1'b0, "GPIO OUT");
        end

        // gpio input, irqs still off
        pins = pbus_pkg::gpio_in_t'($random(seed));
        @(negedge clock);
        gpio_in = pins;
        idle_cycles(3);
        bus_read(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_IN), 32'(pins), 1'b0, "GPIO IN");
        bus_write(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_IN), 32'(~pins), 4'hF, 1'b0, "GPIO IN");
        bus_read(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_IN), 32'(pins), 1'b0, "GPIO IN");  // ro
        check_value("int_o", '0, 32'(int_vec));

        en_model = pbus_pkg::gpio_in_t'($random(seed)) | 8'h01;
        bus_write(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_IRQ_EN), 32'(en_model), 4'hF, 1'b0,
                  "GPIO IRQ_EN");
        bus_read(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_IRQ_ST), '0, 1'b0, "GPIO IRQ_ST");

        // change interrupt, set then w1c
        quiet = ~pbus_pkg::irq_vec_t'(1);           // timers are still idle
        repeat (4) begin
            chg = pbus_pkg::gpio_in_t'($random(seed)) & en_model;
            if (chg == '0) chg = en_model;          // need at least one enabled edge
            pins = pins ^ chg;
            @(negedge clock);
            gpio_in = pins;
            await_irq(0, 1'b1, quiet);
            bus_read(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_IRQ_ST), 32'(chg), 1'b0, "GPIO IRQ_ST");
            bus_read(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_IN), 32'(pins), 1'b0, "GPIO IN");
            bus_write(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_IRQ_ST), 32'(chg), 4'hF, 1'b0,
                      "GPIO IRQ_ST");
            await_irq(0, 1'b0, quiet);
            bus_read(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_IRQ_ST), '0, 1'b0, "GPIO IRQ_ST");
        end

        // one shot expiry on each timer
        for (int t = 0; t < 2; t++) begin
            code  = SLV_CODES[t + 1];
            quiet = ~(pbus_pkg::irq_vec_t'(1) << (t + 1));    // every other line
            tim_load_model[t] = ($unsigned($random(seed)) % 16) + 1;
            bus_write(reg_addr(code, `PBUS_TIM_LOAD), tim_load_model[t], 4'hF, 1'b0, "TIM LOAD");
            bus_read(reg_addr(code, `PBUS_TIM_COUNT), tim_load_model[t], 1'b0, "TIM COUNT");
            ctrl = '0;
            ctrl[`PBUS_TIM_EN_BIT]     = 1'b1;
            ctrl[`PBUS_TIM_IRQ_EN_BIT] = 1'b1;     // reload stays off
            bus_write(reg_addr(code, `PBUS_TIM_CTRL), ctrl, 4'hF, 1'b0, "TIM CTRL");
            tim_ctrl_model[t] = ctrl;
            tim_ctrl_model[t][`PBUS_TIM_EN_BIT] = 1'b0;       // cleared at expiry
            await_irq(t + 1, 1'b1, quiet);
            bus_read(reg_addr(code, `PBUS_TIM_STATUS), 32'd1, 1'b0, "TIM STATUS");
            bus_read(reg_addr(code, `PBUS_TIM_CTRL), tim_ctrl_model[t], 1'b0, "TIM CTRL");
            bus_read(reg_addr(code, `PBUS_TIM_COUNT), '0, 1'b0, "TIM COUNT");
            bus_write(reg_addr(code, `PBUS_TIM_STATUS), 32'd1, 4'hF, 1'b0, "TIM STATUS");
            await_irq(t + 1, 1'b0, quiet);
            bus_read(reg_addr(code, `PBUS_TIM_STATUS), '0, 1'b0, "TIM STATUS");
        end

        // decode errors, unmapped slaves then bad indices
        for (int c = 3; c < 16; c++) begin
            bus_write(reg_addr(c, `PBUS_GPIO_OUT), $random(seed), 4'hF, 1'b1, "unmapped slave");
            bus_read(reg_addr(c, `PBUS_GPIO_OUT), '0, 1'b1, "unmapped slave");
        end
        for (int s = 0; s < 3; s++) begin
            bus_write(reg_addr(SLV_CODES[s], 5), $random(seed), 4'hF, 1'b1, "register index 5");
            bus_read(reg_addr(SLV_CODES[s], 5), '0, 1'b1, "register index 5");
        end

        // nothing moved
        bus_read(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_OUT), 32'(out_model), 1'b0, "GPIO OUT");
        check_value("gpio_out_o", 32'(out_model), 32'(gpio_out));
        bus_read(reg_addr(`PBUS_SLV_GPIO, `PBUS_GPIO_IRQ_EN), 32'(en_model), 1'b0,
                 "GPIO IRQ_EN");
        for (int t = 0; t < 2; t++) begin
            bus_read(reg_addr(SLV_CODES[t + 1], `PBUS_TIM_LOAD), tim_load_model[t], 1'b0,
                     "TIM LOAD");
            bus_read(reg_addr(SLV_CODES[t + 1], `PBUS_TIM_CTRL), tim_ctrl_model[t], 1'b0,
                     "TIM CTRL");
        end
        check_value("int_o", '0, 32'(int_vec));

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/peripheral_bus.sv
////////////////////////////////////////
// peripheral bus top level
// crossbar, gpio and two timers behind
// one valid/ready request/response port
////////////////////////////////////////

`include "pbus_config.svh"

`default_nettype none

module peripheral_bus (
    input  wire logic                 clock_i,
    input  wire logic                 arst_n_i,
    // request channel
    input  wire logic                 req_valid_i,
    input  wire logic                 req_we_i,
    input  wire pbus_pkg::pbus_addr_t req_addr_i,
    input  wire pbus_pkg::pbus_data_t req_wdata_i,
    input  wire pbus_pkg::pbus_strb_t req_strb_i,
    output logic                      req_ready_o,
    // response channel
    output logic                      rsp_valid_o,
    output pbus_pkg::pbus_data_t      rsp_rdata_o,
    output logic                      rsp_err_o,
    input  wire logic                 rsp_ready_i,
    // pins and interrupts
    input  wire pbus_pkg::gpio_in_t   gpio_in_i,
    output pbus_pkg::gpio_out_t       gpio_out_o,
    output pbus_pkg::irq_vec_t        int_o
);

    logic                 acc_we;                       // shared access fields
    pbus_pkg::pbus_idx_t  acc_idx;
    pbus_pkg::pbus_data_t acc_wdata;
    pbus_pkg::pbus_strb_t acc_strb;
    logic                 gpio_sel, tim0_sel, tim1_sel; // one per slave
    pbus_pkg::pbus_data_t gpio_rdata, tim0_rdata, tim1_rdata;
    logic                 gpio_err, tim0_err, tim1_err;
    logic                 gpio_irq, tim0_irq, tim1_irq;

    assign int_o = {tim1_irq, tim0_irq, gpio_irq};      // bit order fixed by sw

    ////////////////////////////////////////
    // crossbar
    ////////////////////////////////////////

    pbus_xbar u_xbar (
        .clock_i      ( clock_i     ),
        .arst_n_i     ( arst_n_i    ),
        .req_valid_i  ( req_valid_i ),
        .req_we_i     ( req_we_i    ),
        .req_addr_i   ( req_addr_i  ),
        .req_wdata_i  ( req_wdata_i ),
        .req_strb_i   ( req_strb_i  ),
        .req_ready_o  ( req_ready_o ),
        .rsp_valid_o  ( rsp_valid_o ),
        .rsp_rdata_o  ( rsp_rdata_o ),
        .rsp_err_o    ( rsp_err_o   ),
        .rsp_ready_i  ( rsp_ready_i ),
        .acc_we_o     ( acc_we      ),
        .acc_idx_o    ( acc_idx     ),
        .acc_wdata_o  ( acc_wdata   ),
        .acc_strb_o   ( acc_strb    ),
        .gpio_sel_o   ( gpio_sel    ),
        .tim0_sel_o   ( tim0_sel    ),
        .tim1_sel_o   ( tim1_sel    ),
        .gpio_rdata_i ( gpio_rdata  ),
        .tim0_rdata_i ( tim0_rdata  ),
        .tim1_rdata_i ( tim1_rdata  ),
        .gpio_err_i   ( gpio_err    ),
        .tim0_err_i   ( tim0_err    ),
        .tim1_err_i   ( tim1_err    )
    );

    ////////////////////////////////////////
    // slaves
    ////////////////////////////////////////

    pbus_gpio u_gpio (
        .clock_i    ( clock_i    ),
        .arst_n_i   ( arst_n_i   ),
        .sel_i      ( gpio_sel   ),
        .we_i       ( acc_we     ),
        .idx_i      ( acc_idx    ),
        .wdata_i    ( acc_wdata  ),
        .strb_i     ( acc_strb   ),
        .gpio_in_i  ( gpio_in_i  ),     // async pins
        .rdata_o    ( gpio_rdata ),
        .err_o      ( gpio_err   ),
        .gpio_out_o ( gpio_out_o ),
        .irq_o      ( gpio_irq   )
    );

    pbus_timer u_tim0 (
        .clock_i  ( clock_i    ),
        .arst_n_i ( arst_n_i   ),
        .sel_i    ( tim0_sel   ),
        .we_i     ( acc_we     ),
        .idx_i    ( acc_idx    ),
        .wdata_i  ( acc_wdata  ),
        .strb_i   ( acc_strb   ),
        .rdata_o  ( tim0_rdata ),
        .err_o    ( tim0_err   ),
        .irq_o    ( tim0_irq   )
    );

    pbus_timer u_tim1 (
        .clock_i  ( clock_i    ),
        .arst_n_i ( arst_n_i   ),
        .sel_i    ( tim1_sel   ),
        .we_i     ( acc_we     ),
        .idx_i    ( acc_idx    ),
        .wdata_i  ( acc_wdata  ),
        .strb_i   ( acc_strb   ),
        .rdata_o  ( tim1_rdata ),
        .err_o    ( tim1_err   ),
        .irq_o    ( tim1_irq   )
    );

endmodule

`default_nettype wire

//--- hw/pbus_timer.sv
////////////////////////////////////////
// count-down timer slave
// one shot or auto reload, expiry irq
////////////////////////////////////////

`include "pbus_config.svh"

`default_nettype none

module pbus_timer (
    input  wire logic                 clock_i,
    input  wire logic                 arst_n_i,
    input  wire logic                 sel_i,
    input  wire logic                 we_i,
    input  wire pbus_pkg::pbus_idx_t  idx_i,
    input  wire pbus_pkg::pbus_data_t wdata_i,
    input  wire pbus_pkg::pbus_strb_t strb_i,
    output pbus_pkg::pbus_data_t      rdata_o,
    output logic                      err_o,
    output logic                      irq_o
);

    logic                 en_q;         // counting
    logic                 reload_q;     // reload at zero
    logic                 irq_en_q;     // expiry irq enable
    logic                 expired_q;    // STATUS bit 0
    pbus_pkg::pbus_data_t load_q;       // LOAD register
    pbus_pkg::pbus_data_t count_q;      // live counter
    pbus_pkg::pbus_data_t ctrl_word;    // CTRL as read back
    pbus_pkg::pbus_data_t wmask;        // strobes expanded to bits
    pbus_pkg::pbus_data_t ctrl_wr;      // CTRL after byte merge
    pbus_pkg::pbus_data_t load_wr;      // LOAD after byte merge
    logic                 wr_en;
    logic                 expire;       // zero reached while enabled
    logic                 st_clr;

    assign err_o   = (idx_i > pbus_pkg::pbus_idx_t'(`PBUS_TIM_STATUS));
    assign wr_en   = sel_i & we_i & ~err_o;
    assign expire  = en_q & (count_q == '0);
    assign st_clr  = wr_en & (idx_i == `PBUS_TIM_STATUS) & wdata_i[0] & wmask[0];
    assign irq_o   = expired_q & irq_en_q;
    assign ctrl_wr = (ctrl_word & ~wmask) | (wdata_i & wmask);
    assign load_wr = (load_q & ~wmask) | (wdata_i & wmask);

    always_comb begin
        for (int b = 0; b < `PBUS_STRB_W; b++) begin
            wmask[b*8 +: 8] = {8{strb_i[b]}};
        end
    end

    always_comb begin
        ctrl_word                       = '0;
        ctrl_word[`PBUS_TIM_EN_BIT]     = en_q;
        ctrl_word[`PBUS_TIM_RELOAD_BIT] = reload_q;
        ctrl_word[`PBUS_TIM_IRQ_EN_BIT] = irq_en_q;
    end

    // read mux
    always_comb begin
        case (idx_i)
            `PBUS_TIM_CTRL:   rdata_o = ctrl_word;
            `PBUS_TIM_LOAD:   rdata_o = load_q;
            `PBUS_TIM_COUNT:  rdata_o = count_q;
            `PBUS_TIM_STATUS: rdata_o = pbus_pkg::pbus_data_t'(expired_q);
            default:          rdata_o = '0;
        endcase
    end

    ////////////////////////////////////////
    // counter and registers
    ////////////////////////////////////////

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q      <= 1'b0;
            reload_q  <= 1'b0;
            irq_en_q  <= 1'b0;
            expired_q <= 1'b0;
            load_q    <= '0;
            count_q   <= '0;
        end else begin
            // counting, L+1 edges from enable to expiry
            if (expire) begin
                if (reload_q) begin
                    count_q <= load_q;              // periodic
                end else begin
                    en_q <= 1'b0;                   // one shot stops
                end
            end else if (en_q) begin
                count_q <= count_q - 1'b1;
            end

            if (st_clr) expired_q <= 1'b0;
            if (expire) expired_q <= 1'b1;          // new expiry beats clear

            // bus writes override the counter
            if (wr_en) begin
                case (idx_i)
                    `PBUS_TIM_CTRL: begin
                        en_q     <= ctrl_wr[`PBUS_TIM_EN_BIT];
                        reload_q <= ctrl_wr[`PBUS_TIM_RELOAD_BIT];
                        irq_en_q <= ctrl_wr[`PBUS_TIM_IRQ_EN_BIT];
                    end
                    `PBUS_TIM_LOAD: begin
                        load_q  <= load_wr;
                        count_q <= load_wr;         // restart from new value
                    end
                    default: ;                      // COUNT ro, STATUS w1c
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pbus_gpio.sv
////////////////////////////////////////
// gpio slave
// output register with byte lanes,
// synchronized inputs, change interrupt
////////////////////////////////////////

`include "pbus_config.svh"

`default_nettype none

module pbus_gpio (
    input  wire logic                 clock_i,
    input  wire logic                 arst_n_i,
    input  wire logic                 sel_i,
    input  wire logic                 we_i,
    input  wire pbus_pkg::pbus_idx_t  idx_i,
    input  wire pbus_pkg::pbus_data_t wdata_i,
    input  wire pbus_pkg::pbus_strb_t strb_i,
    input  wire pbus_pkg::gpio_in_t   gpio_in_i,
    output pbus_pkg::pbus_data_t      rdata_o,
    output logic                      err_o,
    output pbus_pkg::gpio_out_t       gpio_out_o,
    output logic                      irq_o
);

    pbus_pkg::gpio_out_t  out_q;        // OUT register
    pbus_pkg::gpio_in_t   in_meta_q;    // first sync stage
    pbus_pkg::gpio_in_t   in_sync_q;    // IN register value
    pbus_pkg::gpio_in_t   in_prev_q;    // last cycle, for edges
    pbus_pkg::gpio_in_t   irq_en_q;     // per pin change enable
    pbus_pkg::gpio_in_t   irq_st_q;     // sticky change flags
    pbus_pkg::gpio_in_t   in_chg;       // bits that toggled
    pbus_pkg::gpio_in_t   st_clr;       // w1c mask
    pbus_pkg::pbus_data_t wmask;        // strobes expanded to bits
    logic                 wr_en;        // committed write

    assign err_o  = (idx_i > pbus_pkg::pbus_idx_t'(`PBUS_GPIO_IRQ_ST));
    assign wr_en  = sel_i & we_i & ~err_o;     // bad index touches nothing
    assign in_chg = in_sync_q ^ in_prev_q;
    assign st_clr = (wr_en && idx_i == `PBUS_GPIO_IRQ_ST) ?
                    (wdata_i[`PBUS_NUM_GPIO_IN-1:0] & wmask[`PBUS_NUM_GPIO_IN-1:0]) : '0;

    assign gpio_out_o = out_q;
    assign irq_o      = |irq_st_q;

    always_comb begin
        for (int b = 0; b < `PBUS_STRB_W; b++) begin
            wmask[b*8 +: 8] = {8{strb_i[b]}};
        end
    end

    // read mux, IN returns the synchronized pins
    always_comb begin
        case (idx_i)
            `PBUS_GPIO_OUT:    rdata_o = pbus_pkg::pbus_data_t'(out_q);
            `PBUS_GPIO_IN:     rdata_o = pbus_pkg::pbus_data_t'(in_sync_q);
            `PBUS_GPIO_IRQ_EN: rdata_o = pbus_pkg::pbus_data_t'(irq_en_q);
            `PBUS_GPIO_IRQ_ST: rdata_o = pbus_pkg::pbus_data_t'(irq_st_q);
            default:           rdata_o = '0;
        endcase
    end

    ////////////////////////////////////////
    // input path
    ////////////////////////////////////////

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
            in_prev_q <= '0;
            irq_st_q  <= '0;
        end else begin
            in_meta_q <= gpio_in_i;                             // 2 flop sync
            in_sync_q <= in_meta_q;
            in_prev_q <= in_sync_q;
            irq_st_q  <= (irq_st_q & ~st_clr) | (in_chg & irq_en_q);   // set wins
        end
    end

    ////////////////////////////////////////
    // writable registers
    ////////////////////////////////////////

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q    <= '0;
            irq_en_q <= '0;
        end else if (wr_en) begin
            case (idx_i)
                `PBUS_GPIO_OUT: out_q <= (out_q & ~wmask[`PBUS_NUM_GPIO_OUT-1:0])
                                       | (wdata_i[`PBUS_NUM_GPIO_OUT-1:0]
                                          & wmask[`PBUS_NUM_GPIO_OUT-1:0]);
                `PBUS_GPIO_IRQ_EN: irq_en_q <= (irq_en_q & ~wmask[`PBUS_NUM_GPIO_IN-1:0])
                                             | (wdata_i[`PBUS_NUM_GPIO_IN-1:0]
                                                & wmask[`PBUS_NUM_GPIO_IN-1:0]);
                default: ;                                      // IN and status elsewhere
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/pbus_xbar.sv
////////////////////////////////////////
// peripheral bus crossbar
// accepts one request, strobes the
// addressed slave, registers the response
////////////////////////////////////////

`include "pbus_config.svh"

`default_nettype none

module pbus_xbar (
    input  wire logic                 clock_i,
    input  wire logic                 arst_n_i,
    // request channel
    input  wire logic                 req_valid_i,
    input  wire logic                 req_we_i,
    input  wire pbus_pkg::pbus_addr_t req_addr_i,
    input  wire pbus_pkg::pbus_data_t req_wdata_i,
    input  wire pbus_pkg::pbus_strb_t req_strb_i,
    output logic                      req_ready_o,
    // response channel
    output logic                      rsp_valid_o,
    output pbus_pkg::pbus_data_t      rsp_rdata_o,
    output logic                      rsp_err_o,
    input  wire logic                 rsp_ready_i,
    // shared slave access
    output logic                      acc_we_o,
    output pbus_pkg::pbus_idx_t       acc_idx_o,
    output pbus_pkg::pbus_data_t      acc_wdata_o,
    output pbus_pkg::pbus_strb_t      acc_strb_o,
    // per slave strobes and returns
    output logic                      gpio_sel_o,
    output logic                      tim0_sel_o,
    output logic                      tim1_sel_o,
    input  wire pbus_pkg::pbus_data_t gpio_rdata_i,
    input  wire pbus_pkg::pbus_data_t tim0_rdata_i,
    input  wire pbus_pkg::pbus_data_t tim1_rdata_i,
    input  wire logic                 gpio_err_i,
    input  wire logic                 tim0_err_i,
    input  wire logic                 tim1_err_i
);

    pbus_pkg::xbar_state_e                state_q;      // handshake fsm
    logic                                 accept;       // request taken this cycle
    logic [`PBUS_SEL_MSB-`PBUS_SEL_LSB:0] slv_code;     // decoded slave field
    logic                                 mapped;       // slave code exists
    logic                                 slv_err;      // selected slave error
    pbus_pkg::pbus_data_t                 slv_rdata;    // selected slave read data

    ////////////////////////////////////////
    // request side
    ////////////////////////////////////////

    assign req_ready_o = (state_q == pbus_pkg::IDLE);   // one access in flight
    assign rsp_valid_o = (state_q == pbus_pkg::RESP);
    assign accept      = req_valid_i & req_ready_o;
    assign slv_code    = req_addr_i[`PBUS_SEL_MSB:`PBUS_SEL_LSB];

    assign acc_we_o    = req_we_i;                      // shared by all slaves
    assign acc_idx_o   = req_addr_i[`PBUS_IDX_MSB:`PBUS_IDX_LSB];
    assign acc_wdata_o = req_wdata_i;
    assign acc_strb_o  = req_strb_i;

    // select strobes only live in the acceptance cycle
    assign gpio_sel_o  = accept & (slv_code == `PBUS_SLV_GPIO);
    assign tim0_sel_o  = accept & (slv_code == `PBUS_SLV_TIM0);
    assign tim1_sel_o  = accept & (slv_code == `PBUS_SLV_TIM1);

    // return mux
    always_comb begin
        mapped    = 1'b1;
        slv_rdata = '0;
        slv_err   = 1'b0;
        case (slv_code)
            `PBUS_SLV_GPIO: begin
                slv_rdata = gpio_rdata_i;
                slv_err   = gpio_err_i;
            end
            `PBUS_SLV_TIM0: begin
                slv_rdata = tim0_rdata_i;
                slv_err   = tim0_err_i;
            end
            `PBUS_SLV_TIM1: begin
                slv_rdata = tim1_rdata_i;
                slv_err   = tim1_err_i;
            end
            default: mapped = 1'b0;                     // decode error
        endcase
    end

    ////////////////////////////////////////
    // response side
    ////////////////////////////////////////

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= pbus_pkg::IDLE;
        end else begin
            case (state_q)
                pbus_pkg::IDLE: if (accept) state_q <= pbus_pkg::RESP;
                pbus_pkg::RESP: if (rsp_ready_i) state_q <= pbus_pkg::IDLE;
                default:        state_q <= pbus_pkg::IDLE;
            endcase
        end
    end

    // captured at acceptance, held through back-pressure
    always_ff @(posedge clock_i) begin
        if (accept) begin
            rsp_err_o <= ~mapped | slv_err;
            if (req_we_i || !mapped || slv_err) begin
                rsp_rdata_o <= '0;                      // no data for writes or errors
            end else begin
                rsp_rdata_o <= slv_rdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pbus_pkg.sv
////////////////////////////////////////
// peripheral bus types
// vector typedefs and crossbar state
////////////////////////////////////////

`include "pbus_config.svh"

`default_nettype none

package pbus_pkg;

    typedef logic [`PBUS_ADDR_W-1:0] pbus_addr_t;                   // byte address
    typedef logic [`PBUS_DATA_W-1:0] pbus_data_t;                   // register word
    typedef logic [`PBUS_STRB_W-1:0] pbus_strb_t;                   // byte write enables
    typedef logic [`PBUS_IDX_MSB-`PBUS_IDX_LSB:0] pbus_idx_t;      // word index in slave

    typedef logic [`PBUS_NUM_GPIO_OUT-1:0] gpio_out_t;              // output pins
    typedef logic [`PBUS_NUM_GPIO_IN-1:0]  gpio_in_t;               // input pins
    typedef logic [`PBUS_NUM_IRQ-1:0]      irq_vec_t;               // interrupt lines

    // crossbar handshake state
    typedef enum logic {
        IDLE,       // ready for a request
        RESP        // response waiting for the master
    } xbar_state_e;

endpackage

`default_nettype wire

//--- hw/pbus_config.svh
////////////////////////////////////////
// peripheral bus configuration
// widths, address map, register word
// indices and control bit positions
////////////////////////////////////////

`ifndef PBUS_CONFIG_SVH
`define PBUS_CONFIG_SVH

// bus widths
`define PBUS_ADDR_W         32
`define PBUS_DATA_W         32
`define PBUS_STRB_W         4       // one bit per byte lane

// address fields
`define PBUS_SEL_LSB        12      // slave select field
`define PBUS_SEL_MSB        15
`define PBUS_IDX_LSB        2       // word index inside a slave
`define PBUS_IDX_MSB        4

// slave codes, anything else is unmapped
`define PBUS_SLV_GPIO       0
`define PBUS_SLV_TIM0       1
`define PBUS_SLV_TIM1       2

// pins and interrupts
`define PBUS_NUM_GPIO_OUT   8
`define PBUS_NUM_GPIO_IN    8
`define PBUS_NUM_IRQ        3       // tim1, tim0, gpio

// gpio register map
`define PBUS_GPIO_OUT       0
`define PBUS_GPIO_IN        1       // read only
`define PBUS_GPIO_IRQ_EN    2
`define PBUS_GPIO_IRQ_ST    3       // write 1 to clear

// timer register map
`define PBUS_TIM_CTRL       0
`define PBUS_TIM_LOAD       1
`define PBUS_TIM_COUNT      2       // read only
`define PBUS_TIM_STATUS     3       // bit 0 expired, w1c

// timer control bits
`define PBUS_TIM_EN_BIT     0
`define PBUS_TIM_RELOAD_BIT 1
`define PBUS_TIM_IRQ_EN_BIT 2

`endif
